//--- build.f
rtl/csr_index_pkg.sv
rtl/mem_request_pkg.sv
rtl/csr_index_config.sv
rtl/csr_index_sequencer.sv
rtl/request_builder.sv
rtl/request_fifo.sv
rtl/csr_index_generator.sv
test/csr_index_generator_props.sv
test/csr_index_generator_tb.sv

//--- rtl/csr_index_config.sv
// Configuration capture: latches one range configuration while idle and holds it for a run
`timescale 1ns/10ps

module csr_index_config (
    input  logic                          ap_clk,
    input  logic                          areset_engine,
    input  logic                          config_valid,
    input  csr_index_pkg::index_t         config_index_start,
    input  csr_index_pkg::index_t         config_index_end,
    input  csr_index_pkg::stride_t        config_stride,
    input  logic                          config_shift_left,
    input  csr_index_pkg::shift_amount_t  config_shift_amount,
    input  logic                          seq_ready,
    input  logic                          seq_done,
    output logic                          cfg_valid,
    output csr_index_pkg::index_t         cfg_index_start,
    output csr_index_pkg::index_t         cfg_index_end,
    output csr_index_pkg::stride_t        cfg_stride,
    output logic                          cfg_shift_left,
    output csr_index_pkg::shift_amount_t  cfg_shift_amount
);

    logic capture;
    logic run_end;

    // Only the idle sequencer reports ready and done together
    assign capture = config_valid & seq_ready & seq_done;

    // Done without ready is the DONE state
    assign run_end = seq_done & ~seq_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            cfg_valid <= 1'b0;
        end else if (capture) begin
            cfg_valid <= 1'b1;
        end else if (run_end) begin
            cfg_valid <= 1'b0;
        end
    end

    // Fields stay frozen from capture until the next idle period
    always_ff @(posedge ap_clk) begin
        if (capture) begin
            cfg_index_start  <= config_index_start;
            cfg_index_end    <= config_index_end;
            cfg_stride       <= config_stride;
            cfg_shift_left   <= config_shift_left;
            cfg_shift_amount <= config_shift_amount;
        end
    end

endmodule : csr_index_config

//--- rtl/csr_index_generator.sv
// CSR index generator top: configuration, sequencer, request builder and request FIFO
`timescale 1ns/10ps

module csr_index_generator (
    input  logic                          ap_clk,
    input  logic                          areset_engine,
    input  logic                          config_valid,
    input  csr_index_pkg::index_t         config_index_start,
    input  csr_index_pkg::index_t         config_index_end,
    input  csr_index_pkg::stride_t        config_stride,
    input  logic                          config_shift_left,
    input  csr_index_pkg::shift_amount_t  config_shift_amount,
    input  logic                          pause_in,
    input  logic                          request_pop,
    output logic                          request_valid,
    output csr_index_pkg::index_t         request_base,
    output mem_request_pkg::addr_offset_t request_offset,
    output csr_index_pkg::index_t         request_index,
    output logic                          ready_out,
    output logic                          done_out
);

    import csr_index_pkg::*;
    import mem_request_pkg::*;

    // ----------------------------------------------------------------------
    // Internal wires
    // ----------------------------------------------------------------------
    logic          cfg_valid;
    index_t        cfg_index_start;
    index_t        cfg_index_end;
    stride_t       cfg_stride;
    logic          cfg_shift_left;
    shift_amount_t cfg_shift_amount;

    logic          seq_ready;
    logic          seq_done;
    logic          push;
    index_t        push_index;

    logic          wr_en;
    request_word_t wr_word;
    request_word_t rd_word;
    logic          prog_full;

    csr_index_config u_config (
        .ap_clk              (ap_clk),
        .areset_engine       (areset_engine),
        .config_valid        (config_valid),
        .config_index_start  (config_index_start),
        .config_index_end    (config_index_end),
        .config_stride       (config_stride),
        .config_shift_left   (config_shift_left),
        .config_shift_amount (config_shift_amount),
        .seq_ready           (seq_ready),
        .seq_done            (seq_done),
        .cfg_valid           (cfg_valid),
        .cfg_index_start     (cfg_index_start),
        .cfg_index_end       (cfg_index_end),
        .cfg_stride          (cfg_stride),
        .cfg_shift_left      (cfg_shift_left),
        .cfg_shift_amount    (cfg_shift_amount)
    );

    csr_index_sequencer u_sequencer (
        .ap_clk          (ap_clk),
        .areset_engine   (areset_engine),
        .cfg_valid       (cfg_valid),
        .cfg_index_start (cfg_index_start),
        .cfg_index_end   (cfg_index_end),
        .cfg_stride      (cfg_stride),
        .prog_full       (prog_full),
        .pause_in        (pause_in),
        .seq_ready       (seq_ready),
        .seq_done        (seq_done),
        .push            (push),
        .push_index      (push_index)
    );

    request_builder u_builder (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .push             (push),
        .push_index       (push_index),
        .cfg_index_start  (cfg_index_start),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .wr_en            (wr_en),
        .wr_word          (wr_word)
    );

    request_fifo u_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .rd_en         (request_pop),
        .rd_valid      (request_valid),
        .rd_word       (rd_word),
        .prog_full     (prog_full)
    );

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign request_base   = rd_word[REQUEST_BASE_LSB   +: REQUEST_FIELD_W];
    assign request_offset = rd_word[REQUEST_OFFSET_LSB +: REQUEST_FIELD_W];
    assign request_index  = rd_word[REQUEST_INDEX_LSB  +: REQUEST_FIELD_W];

    assign ready_out = seq_ready;
    assign done_out  = seq_done;

endmodule : csr_index_generator

//--- rtl/csr_index_pkg.sv
// Index generation package: index, stride and shift widths plus the run FSM states
package csr_index_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int INDEX_W        = 32;
    localparam int STRIDE_W       = 32;
    localparam int SHIFT_AMOUNT_W = 5;

    // Vertex or edge index walked by the generator
    typedef logic [INDEX_W-1:0] index_t;

    // Step between two successive indices
    typedef logic [STRIDE_W-1:0] stride_t;

    // Shift applied to an index to form the address offset
    typedef logic [SHIFT_AMOUNT_W-1:0] shift_amount_t;

    // ----------------------------------------------------------------------
    // Run states
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        INDEX_GEN_RESET = 3'd0,
        INDEX_GEN_IDLE  = 3'd1,
        INDEX_GEN_SETUP = 3'd2,
        INDEX_GEN_START = 3'd3,
        INDEX_GEN_BUSY  = 3'd4,
        INDEX_GEN_PAUSE = 3'd5,
        INDEX_GEN_DONE  = 3'd6
    } index_gen_state_e;

endpackage : csr_index_pkg

//--- rtl/csr_index_sequencer.sv
// Index sequencer: run FSM that walks start to end by stride and issues one push per step
`timescale 1ns/10ps

module csr_index_sequencer (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    cfg_valid,
    input  csr_index_pkg::index_t   cfg_index_start,
    input  csr_index_pkg::index_t   cfg_index_end,
    input  csr_index_pkg::stride_t  cfg_stride,
    input  logic                    prog_full,
    input  logic                    pause_in,
    output logic                    seq_ready,
    output logic                    seq_done,
    output logic                    push,
    output csr_index_pkg::index_t   push_index
);

    import csr_index_pkg::*;

    index_gen_state_e state;
    index_gen_state_e next_state;

    index_t count;
    logic   at_end;
    logic   stall;

    // ----------------------------------------------------------------------
    // BUSY decision inputs
    // ----------------------------------------------------------------------
    assign at_end = (count >= cfg_index_end);

    // FIFO back-pressure and external pause hold the walk alike
    assign stall = prog_full | pause_in;

    // ----------------------------------------------------------------------
    // State register and next state
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= INDEX_GEN_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INDEX_GEN_RESET: begin
                next_state = INDEX_GEN_IDLE;
            end
            INDEX_GEN_IDLE: begin
                if (cfg_valid) begin
                    next_state = INDEX_GEN_SETUP;
                end
            end
            INDEX_GEN_SETUP: begin
                next_state = INDEX_GEN_START;
            end
            INDEX_GEN_START: begin
                next_state = INDEX_GEN_BUSY;
            end
            INDEX_GEN_BUSY: begin
                // End check wins over a stall so an empty range never waits
                if (at_end) begin
                    next_state = INDEX_GEN_DONE;
                end else if (stall) begin
                    next_state = INDEX_GEN_PAUSE;
                end
            end
            INDEX_GEN_PAUSE: begin
                if (!stall) begin
                    next_state = INDEX_GEN_BUSY;
                end
            end
            INDEX_GEN_DONE: begin
                next_state = INDEX_GEN_IDLE;
            end
            default: begin
                next_state = INDEX_GEN_RESET;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Index counter
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == INDEX_GEN_SETUP) begin
            count <= cfg_index_start;
        end else if (push) begin
            count <= count + cfg_stride;
        end
    end

    // One push per counter step, decided in the same cycle as the pause check
    assign push       = (state == INDEX_GEN_BUSY) & ~at_end & ~stall;
    assign push_index = count;

    // Status decode
    assign seq_ready = (state == INDEX_GEN_IDLE);
    assign seq_done  = (state == INDEX_GEN_IDLE) | (state == INDEX_GEN_DONE);

endmodule : csr_index_sequencer

//--- rtl/mem_request_pkg.sv
// Memory request package: request word layout and request FIFO sizing
package mem_request_pkg;

    // ----------------------------------------------------------------------
    // Request word layout with the base on top and the index at the bottom
    // ----------------------------------------------------------------------
    localparam int REQUEST_FIELD_W    = 32;
    localparam int REQUEST_WORD_W     = 3 * REQUEST_FIELD_W;
    localparam int REQUEST_INDEX_LSB  = 0;
    localparam int REQUEST_OFFSET_LSB = REQUEST_INDEX_LSB + REQUEST_FIELD_W;
    localparam int REQUEST_BASE_LSB   = REQUEST_OFFSET_LSB + REQUEST_FIELD_W;

    typedef logic [REQUEST_FIELD_W-1:0] addr_offset_t;
    typedef logic [REQUEST_WORD_W-1:0]  request_word_t;

    // ----------------------------------------------------------------------
    // Request FIFO sizing
    // ----------------------------------------------------------------------
    localparam int REQUEST_FIFO_DEPTH  = 16;
    localparam int REQUEST_FIFO_ADDR_W = $clog2(REQUEST_FIFO_DEPTH);

    // Leaves room for the writes still in flight when the flag rises
    localparam int REQUEST_PROG_THRESH = 8;

    // One extra bit so a full buffer can be counted
    typedef logic [REQUEST_FIFO_ADDR_W:0] fifo_count_t;

endpackage : mem_request_pkg

//--- rtl/request_builder.sv
// Request builder: forms the base, shifted offset and index word for each pushed index
`timescale 1ns/10ps

module request_builder (
    input  logic                           ap_clk,
    input  logic                           areset_engine,
    input  logic                           push,
    input  csr_index_pkg::index_t          push_index,
    input  csr_index_pkg::index_t          cfg_index_start,
    input  logic                           cfg_shift_left,
    input  csr_index_pkg::shift_amount_t   cfg_shift_amount,
    output logic                           wr_en,
    output mem_request_pkg::request_word_t wr_word
);

    import mem_request_pkg::*;

    addr_offset_t  offset;
    request_word_t word_next;

    // Shift direction comes from the captured configuration
    always_comb begin
        if (cfg_shift_left) begin
            offset = push_index << cfg_shift_amount;
        end else begin
            offset = push_index >> cfg_shift_amount;
        end
    end

    always_comb begin
        word_next = '0;
        word_next[REQUEST_BASE_LSB   +: REQUEST_FIELD_W] = cfg_index_start;
        word_next[REQUEST_OFFSET_LSB +: REQUEST_FIELD_W] = offset;
        word_next[REQUEST_INDEX_LSB  +: REQUEST_FIELD_W] = push_index;
    end

    // One register stage between push and FIFO write
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= push;
        end
    end

    always_ff @(posedge ap_clk) begin
        wr_word <= word_next;
    end

endmodule : request_builder

//--- rtl/request_fifo.sv
// Request FIFO: 16-deep synchronous buffer with programmable full and registered read port
`timescale 1ns/10ps

module request_fifo (
    input  logic                           ap_clk,
    input  logic                           areset_engine,
    input  logic                           wr_en,
    input  mem_request_pkg::request_word_t wr_word,
    input  logic                           rd_en,
    output logic                           rd_valid,
    output mem_request_pkg::request_word_t rd_word,
    output logic                           prog_full
);

    import mem_request_pkg::*;

    request_word_t mem [REQUEST_FIFO_DEPTH];

    logic [REQUEST_FIFO_ADDR_W-1:0] wr_ptr;
    logic [REQUEST_FIFO_ADDR_W-1:0] rd_ptr;
    fifo_count_t                    count;

    logic full;
    logic empty;
    logic wr_accept;
    logic rd_accept;

    // ----------------------------------------------------------------------
    // Flags
    // ----------------------------------------------------------------------
    assign full      = (count == fifo_count_t'(REQUEST_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= fifo_count_t'(REQUEST_PROG_THRESH));

    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rd_valid <= rd_accept;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_word;
        end
        if (rd_accept) begin
            rd_word <= mem[rd_ptr];
        end
    end

endmodule : request_fifo

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides the result from sim.log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module csr_index_generator_tb -Mdir obj_dir -o csr_index_sim \
    && ./obj_dir/csr_index_sim | tee sim.log \
    || echo "simulation build or run returned an error"

grep -qx "test passed" sim.log && exit 0 || exit 1

//--- test/csr_index_generator_props.sv
// Request FIFO properties: no write when full, read valid only after a pop, quiet in reset
`timescale 1ns/10ps

module csr_index_generator_props (
    input logic ap_clk,
    input logic areset_engine,
    input logic wr_en,
    input logic full,
    input logic rd_en,
    input logic rd_valid
);

    // Count of failed assertions
    int assert_errors = 0;

    no_write_when_full: assert property (@(posedge ap_clk) disable iff (areset_engine)
        !(wr_en && full))
    else begin
        assert_errors++;
        $error("request FIFO written while full");
    end

    valid_follows_pop: assert property (@(posedge ap_clk) disable iff (areset_engine)
        rd_valid |-> $past(rd_en))
    else begin
        assert_errors++;
        $error("rd_valid without a pop in the cycle before");
    end

    valid_low_in_reset: assert property (@(posedge ap_clk) areset_engine |=> !rd_valid)
    else begin
        assert_errors++;
        $error("rd_valid high during reset");
    end

endmodule : csr_index_generator_props

bind request_fifo csr_index_generator_props u_props (
    .ap_clk        (ap_clk),
    .areset_engine (areset_engine),
    .wr_en         (wr_en),
    .full          (full),
    .rd_en         (rd_en),
    .rd_valid      (rd_valid)
);

//--- test/csr_index_generator_tb.sv
// CSR index generator testbench: range runs, back-pressure and pause against a reference model
`timescale 1ns/10ps

module csr_index_generator_tb;

    import csr_index_pkg::*;
    import mem_request_pkg::*;

    logic          ap_clk = 1'b0;
    logic          areset_engine = 1'b1;
    logic          config_valid;
    index_t        config_index_start;
    index_t        config_index_end;
    stride_t       config_stride;
    logic          config_shift_left;
    shift_amount_t config_shift_amount;
    logic          pause_in = 1'b0;
    logic          request_pop = 1'b1;
    logic          request_valid;
    index_t        request_base;
    addr_offset_t  request_offset;
    index_t        request_index;
    logic          ready_out;
    logic          done_out;

    // Expected configuration of the current run
    index_t        exp_start;
    stride_t       exp_stride;
    logic          exp_left;
    shift_amount_t exp_amount;
    int            exp_total = 0;
    int            rx_count = 0;
    logic [95:0]   exp_word;

    // Pop modes are high, held low and random, numbered 0 to 2
    int            pop_mode = 0;
    // Pause modes are low, random and held high, numbered 0 to 2
    int            pause_mode = 0;
    logic [31:0]   lcg_state = 32'd41;

    csr_index_generator u_dut (.*);

    always #4 ap_clk = ~ap_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Base, offset and index of the k-th request of a range
    function automatic logic [95:0] ref_request(input index_t start, input stride_t stride,
                                                input logic left, input shift_amount_t amt,
                                                input int k);
        index_t idx;
        index_t off;
        int     i;
        idx = start + index_t'(k) * stride;
        off = idx;
        // Each step of the shift amount doubles or halves the offset
        for (i = 0; i < int'(amt); i++) begin
            if (left) begin
                off = off * 32'd2;
            end else begin
                off = off / 32'd2;
            end
        end
        return {start, off, idx};
    endfunction

    function automatic int range_length(input index_t start, input index_t stop,
                                        input stride_t stride);
        int     n;
        index_t idx;
        n = 0;
        idx = start;
        while (idx < stop) begin
            n++;
            idx = idx + stride;
        end
        return n;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            abort_run({"wrong value on ", name});
        end
    endtask

    task automatic wait_ready(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (ready_out !== level) begin
            @(negedge ap_clk);
            n++;
            if (n > max_cycles) begin
                abort_run({"timed out waiting for ", what});
            end
        end
    endtask

    task automatic wait_requests(input int max_cycles);
        int n;
        n = 0;
        while (rx_count < exp_total) begin
            @(negedge ap_clk);
            n++;
            if (n > max_cycles) begin
                abort_run("timed out waiting for the remaining requests");
            end
        end
    endtask

    task automatic set_expected(input index_t start, input index_t stop, input stride_t stride,
                                input logic left, input shift_amount_t amt);
        exp_start  = start;
        exp_stride = stride;
        exp_left   = left;
        exp_amount = amt;
        exp_total  = range_length(start, stop, stride);
        rx_count   = 0;
    endtask

    task automatic pulse_config(input index_t start, input index_t stop, input stride_t stride,
                                input logic left, input shift_amount_t amt);
        config_index_start  = start;
        config_index_end    = stop;
        config_stride       = stride;
        config_shift_left   = left;
        config_shift_amount = amt;
        config_valid        = 1'b1;
        @(negedge ap_clk);
        config_valid = 1'b0;
    endtask

    task automatic expect_run(input int max_cycles);
        wait_ready(1'b0, 16, "the generator to start a run");
        wait_ready(1'b1, max_cycles, "the generator to finish a run");
        check("done_out", {31'd0, done_out}, 32'd1);
        wait_requests(max_cycles);
        repeat (8) @(negedge ap_clk);
    endtask

    task automatic run_range(input index_t start, input index_t stop, input stride_t stride,
                             input logic left, input shift_amount_t amt);
        set_expected(start, stop, stride, left, amt);
        pulse_config(start, stop, stride, left, amt);
        expect_run(2000);
    endtask

    // Pop and pause levels
    always @(negedge ap_clk) begin
        lcg_state = lcg_next(lcg_state);
        case (pop_mode)
            0:       request_pop <= 1'b1;
            1:       request_pop <= 1'b0;
            default: request_pop <= lcg_state[16];
        endcase
        pause_in <= (pause_mode == 2) ||
                    ((pause_mode == 1) && (lcg_state[19:18] == 2'b00));
    end

    // Collector
    always @(negedge ap_clk) begin
        if (!areset_engine && request_valid === 1'b1) begin
            if (rx_count >= exp_total) begin
                abort_run("a request arrived beyond the end of the range");
            end
            exp_word = ref_request(exp_start, exp_stride, exp_left, exp_amount, rx_count);
            check("request_base", request_base, exp_word[95:64]);
            check("request_offset", request_offset, exp_word[63:32]);
            check("request_index", request_index, exp_word[31:0]);
            rx_count++;
        end
    end

    initial begin
        config_valid        = 1'b0;
        config_index_start  = '0;
        config_index_end    = '0;
        config_stride       = '0;
        config_shift_left   = 1'b0;
        config_shift_amount = '0;

        repeat (5) @(negedge ap_clk);
        check("ready_out", {31'd0, ready_out}, 32'd0);
        check("done_out", {31'd0, done_out}, 32'd0);
        areset_engine = 1'b0;
        wait_ready(1'b1, 10, "ready after reset");
        check("done_out", {31'd0, done_out}, 32'd1);
        repeat (10) @(negedge ap_clk);

        run_range(32'd10, 32'd20, 32'd1, 1'b1, 5'd2);
        run_range(32'd3, 32'd40, 32'd5, 1'b0, 5'd1);
        run_range(32'd50, 32'd50, 32'd3, 1'b1, 5'd1);
        run_range(32'd60, 32'd20, 32'd1, 1'b0, 5'd0);

        // Reader stalled while the run fills the FIFO
        pop_mode = 1;
        set_expected(32'd200, 32'd230, 32'd1, 1'b1, 5'd3);
        pulse_config(32'd200, 32'd230, 32'd1, 1'b1, 5'd3);
        repeat (40) @(negedge ap_clk);
        pop_mode = 2;
        expect_run(2000);

        // Random pause with a strobe that must be ignored mid-run
        pop_mode   = 0;
        pause_mode = 1;
        set_expected(32'd100, 32'd140, 32'd2, 1'b1, 5'd3);
        pulse_config(32'd100, 32'd140, 32'd2, 1'b1, 5'd3);
        wait_ready(1'b0, 16, "the generator to start a run");
        repeat (5) @(negedge ap_clk);
        pulse_config(32'd0, 32'd1000, 32'd7, 1'b0, 5'd4);

        // Held pause drains the builder and FIFO, then no request may follow
        pause_mode = 2;
        repeat (6) @(negedge ap_clk);
        repeat (20) begin
            check("request_valid", {31'd0, request_valid}, 32'd0);
            @(negedge ap_clk);
        end
        pause_mode = 1;
        expect_run(2000);
        pause_mode = 0;
        repeat (10) begin
            check("ready_out", {31'd0, ready_out}, 32'd1);
            @(negedge ap_clk);
        end

        if (u_dut.u_fifo.u_props.assert_errors == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("a FIFO assertion failed during the run");
        end
    end

endmodule : csr_index_generator_tb
